//--- rtl/fll_pkg.sv
`default_nettype none

package fll_pkg;

    // Word framing in every bit-clock domain
    localparam int BIT_CLOCKS_PER_WORD = 64;
    localparam int BITCNT_W            = 8;
    localparam int WORDCNT_W           = 32;

    // Sample length and gap counters
    localparam int SAMPLE_W = 16;

    // Compute phase timing, all in compute timer ticks
    localparam logic [3:0] COMPUTE_LAST = 4'd15;
    localparam logic [3:0] COPY_CYCLES  = 4'd4;
    localparam logic [3:0] COMPARE_AT   = 4'd8;
    localparam logic [3:0] DECIDE_AT    = 4'd10;

    // Tracked domains and their loop indices
    localparam int NUM_DOMAINS = 2;
    localparam int DOM_MASTER  = 0;
    localparam int DOM_LOCAL   = 1;

    typedef enum logic [1:0] {
        IDLE,
        SAMPLE,
        COMPUTE,
        GAP
    } fll_state_e;

    // Quasi-static configuration in the local domain
    typedef struct packed {
        logic                enable;
        logic [SAMPLE_W-1:0] sample_len;
        logic [SAMPLE_W-1:0] sample_gap;
    } fll_cfg_t;

    typedef struct packed {
        logic copy_req;
        logic sample_en;
        logic sample_load;
        logic sample_load_d;
    } seq_ctrl_t;

    typedef struct packed {
        logic speedup;
        logic slowdown;
    } fll_adjust_t;

endpackage

`default_nettype wire

//--- rtl/fll_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module fll_sequencer (
    input  logic                rst,
    input  logic                bitclk_local,
    input  fll_pkg::fll_cfg_t   cfg_i,
    input  logic                enable_sync_i,
    output fll_pkg::seq_ctrl_t  ctrl_o,
    output logic                compare_stb_o,
    output logic                decide_stb_o,
    output fll_pkg::fll_state_e state_o
);

    import fll_pkg::*;

    fll_state_e                     state_q;
    fll_state_e                     state_d;
    logic [$bits(COMPUTE_LAST)-1:0] timer_q;
    logic [SAMPLE_W-1:0]            sample_cnt_q;
    logic [SAMPLE_W-1:0]            gap_cnt_q;
    logic                           gap_en_q;
    seq_ctrl_t                      ctrl_q;

    // Loop through sample, compute and gap while enabled
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (enable_sync_i)
                    state_d = SAMPLE;
            end
            SAMPLE: begin
                if (sample_cnt_q == '0)
                    state_d = COMPUTE;
            end
            COMPUTE: begin
                if (timer_q == COMPUTE_LAST)
                    state_d = GAP;
            end
            GAP: begin
                if (gap_cnt_q == '0)
                    state_d = enable_sync_i ? SAMPLE : IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge rst or posedge bitclk_local) begin
        if (bitclk_local) begin
            state_q <= IDLE;
            timer_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == COMPUTE)
                timer_q <= timer_q + 1'b1;
            else
                timer_q <= '0;
        end
    end

    // Registered control levels
    always_ff @(posedge rst or posedge bitclk_local) begin
        if (bitclk_local) begin
            ctrl_q   <= '0;
            gap_en_q <= 1'b0;
        end else begin
            // Copy request covers the first few compute cycles
            ctrl_q.copy_req      <= (state_q == COMPUTE) && (timer_q < COPY_CYCLES);
            ctrl_q.sample_en     <= (state_q == SAMPLE);
            ctrl_q.sample_load_d <= ctrl_q.sample_load;
            // Load stays up at least two cycles so the master side sees it
            ctrl_q.sample_load   <= (state_q == IDLE) || (state_q == GAP) ||
                                    (ctrl_q.sample_load && !ctrl_q.sample_load_d);
            gap_en_q             <= (state_q == GAP);
        end
    end

    // Local sample and gap counters saturate at zero
    always_ff @(posedge rst or posedge bitclk_local) begin
        if (bitclk_local) begin
            sample_cnt_q <= '0;
            gap_cnt_q    <= '0;
        end else begin
            if (ctrl_q.sample_load)
                sample_cnt_q <= cfg_i.sample_len;
            else if (ctrl_q.sample_en && (sample_cnt_q != '0))
                sample_cnt_q <= sample_cnt_q - 1'b1;

            if (!gap_en_q)
                gap_cnt_q <= cfg_i.sample_gap;
            else if (gap_cnt_q != '0)
                gap_cnt_q <= gap_cnt_q - 1'b1;
        end
    end

    assign compare_stb_o = (state_q == COMPUTE) && (timer_q == COMPARE_AT);
    assign decide_stb_o  = (state_q == COMPUTE) && (timer_q == DECIDE_AT);
    assign ctrl_o        = ctrl_q;
    assign state_o       = state_q;

endmodule

`default_nettype wire

//--- rtl/domain_word_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module domain_word_tracker (
    input  logic                          clk_i,
    input  logic                          bitclk_local,
    input  logic                          enable_i,
    input  logic                          copy_req_i,
    output logic                          enable_sync_o,
    output logic [fll_pkg::WORDCNT_W-1:0] shadow_o
);

    import fll_pkg::*;

    logic                 en_r1;
    logic                 en_r2;
    logic                 en_sync;
    logic                 copy_r1;
    logic                 copy_r2;
    logic                 copy_stb;
    logic [BITCNT_W-1:0]  bitcnt_q;
    logic [WORDCNT_W-1:0] wordcnt_q;
    logic [WORDCNT_W-1:0] shadow_q;

    // Enable only follows once two samples agree
    always_ff @(posedge clk_i or posedge bitclk_local) begin
        if (bitclk_local) begin
            en_r1    <= 1'b0;
            en_r2    <= 1'b0;
            en_sync  <= 1'b0;
            copy_r1  <= 1'b0;
            copy_r2  <= 1'b0;
            copy_stb <= 1'b0;
        end else begin
            en_r1 <= enable_i;
            en_r2 <= en_r1;
            if (en_r1 == en_r2)
                en_sync <= en_r2;
            copy_r1  <= copy_req_i;
            copy_r2  <= copy_r1;
            // Single pulse on the rising edge of the copy request
            copy_stb <= copy_r1 && !copy_r2;
        end
    end

    // Bit and word counters, held clear while disabled
    always_ff @(posedge clk_i or posedge bitclk_local) begin
        if (bitclk_local) begin
            bitcnt_q  <= '0;
            wordcnt_q <= '0;
        end else if (!en_sync) begin
            bitcnt_q  <= '0;
            wordcnt_q <= '0;
        end else if (bitcnt_q == BITCNT_W'(BIT_CLOCKS_PER_WORD - 1)) begin
            bitcnt_q  <= '0;
            wordcnt_q <= wordcnt_q + 1'b1;
        end else begin
            bitcnt_q  <= bitcnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (copy_stb)
            shadow_q <= wordcnt_q;
    end

    assign enable_sync_o = en_sync;
    assign shadow_o      = shadow_q;

endmodule

`default_nettype wire

//--- rtl/master_sample_counter.sv
`timescale 1ns/1ps
`default_nettype none

module master_sample_counter (
    input  logic                         bitclk_master_i,
    input  logic                         bitclk_local,
    input  fll_pkg::seq_ctrl_t           ctrl_i,
    input  logic [fll_pkg::SAMPLE_W-1:0] sample_len_i,
    output logic [fll_pkg::SAMPLE_W-1:0] sample_cnt_o
);

    import fll_pkg::*;

    logic                en_r1;
    logic                en_r2;
    logic                en_sync;
    logic                load_r1;
    logic                load_r2;
    logic                load_sync;
    logic [SAMPLE_W-1:0] sample_cnt_q;

    always_ff @(posedge bitclk_master_i or posedge bitclk_local) begin
        if (bitclk_local) begin
            en_r1     <= 1'b0;
            en_r2     <= 1'b0;
            en_sync   <= 1'b0;
            load_r1   <= 1'b0;
            load_r2   <= 1'b0;
            load_sync <= 1'b0;
        end else begin
            en_r1 <= ctrl_i.sample_en;
            en_r2 <= en_r1;
            if (en_r1 == en_r2)
                en_sync <= en_r2;
            // Widened load is caught by either stage
            load_r1   <= ctrl_i.sample_load;
            load_r2   <= ctrl_i.sample_load_d;
            load_sync <= load_r1 || load_r2;
        end
    end

    // Wraps below zero, so the top bit marks a faster master clock
    always_ff @(posedge bitclk_master_i or posedge bitclk_local) begin
        if (bitclk_local)
            sample_cnt_q <= '0;
        else if (load_sync)
            sample_cnt_q <= sample_len_i;
        else if (en_sync)
            sample_cnt_q <= sample_cnt_q - 1'b1;
    end

    assign sample_cnt_o = sample_cnt_q;

endmodule

`default_nettype wire

//--- rtl/fll_decision.sv
`timescale 1ns/1ps
`default_nettype none

module fll_decision (
    input  logic                          rst,
    input  logic                          bitclk_local,
    input  logic                          compare_stb_i,
    input  logic                          decide_stb_i,
    input  logic [fll_pkg::WORDCNT_W-1:0] shadow_master_i,
    input  logic [fll_pkg::WORDCNT_W-1:0] shadow_local_i,
    input  logic [fll_pkg::SAMPLE_W-1:0]  sample_cnt_master_i,
    output fll_pkg::fll_adjust_t          adjust_o
);

    import fll_pkg::*;

    logic        aligned_q;
    logic        local_ahead_q;
    logic        master_ahead_q;
    logic        cnt_neg;
    logic        cnt_zero;
    logic        cnt_pos;
    logic        want_speedup;
    logic        want_slowdown;
    fll_adjust_t adjust_q;

    // Word count comparison, skipped when only one side has rolled over
    always_ff @(posedge rst or posedge bitclk_local) begin
        if (bitclk_local) begin
            aligned_q      <= 1'b0;
            local_ahead_q  <= 1'b0;
            master_ahead_q <= 1'b0;
        end else if (compare_stb_i &&
                     (shadow_local_i[WORDCNT_W-1] == shadow_master_i[WORDCNT_W-1])) begin
            aligned_q      <= (shadow_local_i == shadow_master_i);
            local_ahead_q  <= (shadow_local_i > shadow_master_i);
            master_ahead_q <= (shadow_local_i < shadow_master_i);
        end
    end

    // Sign of the master residue gives the clock ratio
    assign cnt_neg  = sample_cnt_master_i[SAMPLE_W-1];
    assign cnt_zero = (sample_cnt_master_i == '0);
    assign cnt_pos  = !cnt_neg && !cnt_zero;

    assign want_speedup  = (cnt_neg && (aligned_q || master_ahead_q)) ||
                           (cnt_zero && master_ahead_q);
    assign want_slowdown = (cnt_pos && (aligned_q || local_ahead_q)) ||
                           (cnt_zero && local_ahead_q);

    // One-cycle pulses, speedup has priority
    always_ff @(posedge rst or posedge bitclk_local) begin
        if (bitclk_local) begin
            adjust_q <= '0;
        end else begin
            adjust_q.speedup  <= decide_stb_i && want_speedup;
            adjust_q.slowdown <= decide_stb_i && want_slowdown && !want_speedup;
        end
    end

    assign adjust_o = adjust_q;

endmodule

`default_nettype wire

//--- rtl/fll_top.sv
`timescale 1ns/1ps
`default_nettype none

module fll_top (
    input  logic                 rst,
    input  logic                 bitclk_local,
    input  logic                 bitclk_master_i,
    input  fll_pkg::fll_cfg_t    cfg_i,
    output fll_pkg::fll_adjust_t adjust_o
);

    import fll_pkg::*;

    seq_ctrl_t            seq_ctrl;
    fll_state_e           seq_state;
    logic                 compare_stb;
    logic                 decide_stb;
    logic [NUM_DOMAINS-1:0] enable_sync;
    logic [WORDCNT_W-1:0] shadow_cnt [NUM_DOMAINS];
    logic [SAMPLE_W-1:0]  sample_cnt_master;

    fll_sequencer u_seq (
        .rst           (rst),
        .bitclk_local  (bitclk_local),
        .cfg_i         (cfg_i),
        .enable_sync_i (enable_sync[DOM_LOCAL]),
        .ctrl_o        (seq_ctrl),
        .compare_stb_o (compare_stb),
        .decide_stb_o  (decide_stb),
        .state_o       (seq_state)
    );

    // One tracker per bit-clock domain
    for (genvar g = 0; g < NUM_DOMAINS; g++) begin : g_dom
        domain_word_tracker u_tracker (
            .clk_i         ((g == DOM_MASTER) ? bitclk_master_i : rst),
            .bitclk_local  (bitclk_local),
            .enable_i      (cfg_i.enable),
            .copy_req_i    (seq_ctrl.copy_req),
            .enable_sync_o (enable_sync[g]),
            .shadow_o      (shadow_cnt[g])
        );
    end

    master_sample_counter u_master_cnt (
        .bitclk_master_i (bitclk_master_i),
        .bitclk_local    (bitclk_local),
        .ctrl_i          (seq_ctrl),
        .sample_len_i    (cfg_i.sample_len),
        .sample_cnt_o    (sample_cnt_master)
    );

    fll_decision u_decision (
        .rst                 (rst),
        .bitclk_local        (bitclk_local),
        .compare_stb_i       (compare_stb),
        .decide_stb_i        (decide_stb),
        .shadow_master_i     (shadow_cnt[DOM_MASTER]),
        .shadow_local_i      (shadow_cnt[DOM_LOCAL]),
        .sample_cnt_master_i (sample_cnt_master),
        .adjust_o            (adjust_o)
    );

endmodule

`default_nettype wire

//--- tests/fll_props.sv
`timescale 1ns/1ps
`default_nettype none

module fll_props (
    input logic                 rst,
    input logic                 bitclk_local,
    input fll_pkg::fll_adjust_t adjust_o
);

    int unsigned fail_count = 0;

    // Speedup and slowdown are mutually exclusive
    a_exclusive: assert property (@(posedge rst) disable iff (bitclk_local)
        !(adjust_o.speedup && adjust_o.slowdown))
    else begin
        fail_count++;
        $error("speedup and slowdown high in the same cycle");
    end

    // Each pulse is a single local cycle
    a_speedup_one: assert property (@(posedge rst) disable iff (bitclk_local)
        adjust_o.speedup |=> !adjust_o.speedup)
    else begin
        fail_count++;
        $error("speedup held longer than one cycle");
    end

    a_slowdown_one: assert property (@(posedge rst) disable iff (bitclk_local)
        adjust_o.slowdown |=> !adjust_o.slowdown)
    else begin
        fail_count++;
        $error("slowdown held longer than one cycle");
    end

    a_reset_zero: assert property (@(posedge rst) bitclk_local |-> (adjust_o == '0))
    else begin
        fail_count++;
        $error("adjust_o not zero during reset");
    end

endmodule

bind fll_top fll_props u_props (
    .rst          (rst),
    .bitclk_local (bitclk_local),
    .adjust_o     (adjust_o)
);

`default_nettype wire

//--- tests/fll_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fll_tb;

    import fll_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int SAMPLE_LEN   = 256;
    localparam int SPACING_TOL  = 8;
    localparam int IDLE_CYCLES  = 2000;

    localparam fll_adjust_t ADJ_NONE     = '{speedup: 1'b0, slowdown: 1'b0};
    localparam fll_adjust_t ADJ_SPEEDUP  = '{speedup: 1'b1, slowdown: 1'b0};
    localparam fll_adjust_t ADJ_SLOWDOWN = '{speedup: 1'b0, slowdown: 1'b1};

    // Local bit clock on port rst and reset on port bitclk_local
    logic        rst;
    logic        bitclk_local;
    logic        bitclk_master;
    fll_cfg_t    cfg;
    fll_adjust_t adjust;

    realtime     master_half = 15.0;
    int          cycle_no;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          gap;
    int          pulse_cycles[$];

    fll_top DUT (
        .rst             (rst),
        .bitclk_local    (bitclk_local),
        .bitclk_master_i (bitclk_master),
        .cfg_i           (cfg),
        .adjust_o        (adjust)
    );

    always #20 rst = ~rst;

    always #(master_half) bitclk_master = ~bitclk_master;

    always @(posedge rst)
        cycle_no <= cycle_no + 1;

    // Nominal loop of sample_len in SAMPLE, 16 in COMPUTE and sample_gap in GAP
    function automatic int loop_cycles();
        return SAMPLE_LEN + gap + 16;
    endfunction

    task automatic check_adjust(input string name, input fll_adjust_t got,
                                input fll_adjust_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_state(input string name, input fll_state_e got,
                               input fll_state_e exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %s expected %s", $time, name, got.name(), exp.name());
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d error(s)", name, errors - errors_before);
        end
    endtask

    // Every pulse in the window must be of the expected kind
    task automatic watch_pulses(input int cycles, input fll_adjust_t kind);
        pulse_cycles.delete();
        for (int i = 0; i < cycles; i++) begin
            @(negedge rst);
            if (adjust != ADJ_NONE) begin
                pulse_cycles.push_back(cycle_no);
                check_adjust("adjust_o", adjust, kind);
            end
        end
    endtask

    task automatic idle_after_reset();
        int errors_before;
        errors_before = errors;
        @(negedge rst);
        check_adjust("adjust_o", adjust, ADJ_NONE);
        check_state("state_o", DUT.seq_state, IDLE);
        watch_pulses(IDLE_CYCLES, ADJ_NONE);
        check_state("state_o", DUT.seq_state, IDLE);
        finish_test("reset_idle", errors_before);
    endtask

    task automatic fast_master_speedup();
        int errors_before;
        errors_before = errors;
        master_half = 15.0;
        @(negedge rst);
        cfg.enable = 1'b1;
        watch_pulses(5 * loop_cycles() + 32, ADJ_SPEEDUP);
        if (pulse_cycles.size() == 0) begin
            $display("no speedup pulse seen within five loops");
            errors++;
        end
        finish_test("fast_master", errors_before);
    endtask

    task automatic pulse_spacing();
        int errors_before;
        int spacing;
        errors_before = errors;
        if (pulse_cycles.size() < 2) begin
            $display("fewer than two pulses recorded, spacing not measurable");
            errors++;
        end
        for (int i = 1; i < pulse_cycles.size(); i++) begin
            spacing = pulse_cycles[i] - pulse_cycles[i-1];
            if (spacing < loop_cycles() - SPACING_TOL ||
                spacing > loop_cycles() + SPACING_TOL) begin
                $display("FAIL %0t pulse spacing got %0d expected %0d +/- %0d",
                         $time, spacing, loop_cycles(), SPACING_TOL);
                errors++;
            end
        end
        finish_test("pulse_spacing", errors_before);
    endtask

    task automatic disable_mid_run();
        int errors_before;
        int waited;
        bit seen;
        errors_before = errors;
        seen   = 1'b0;
        waited = 0;
        // Drop the enable right after a pulse while still in COMPUTE
        while (!seen && waited < 2 * loop_cycles()) begin
            @(negedge rst);
            waited++;
            seen = (adjust != ADJ_NONE);
        end
        if (!seen) begin
            $display("no pulse seen before dropping the enable");
            errors++;
        end
        cfg.enable = 1'b0;
        waited = 0;
        while (DUT.seq_state != IDLE && waited < loop_cycles() + SPACING_TOL) begin
            @(negedge rst);
            waited++;
            check_adjust("adjust_o", adjust, ADJ_NONE);
        end
        if (DUT.seq_state != IDLE) begin
            $display("state did not return to IDLE within %0d cycles", waited);
            errors++;
        end
        watch_pulses(IDLE_CYCLES, ADJ_NONE);
        finish_test("disable", errors_before);
    endtask

    task automatic slow_master_slowdown();
        int errors_before;
        errors_before = errors;
        master_half = 27.0;
        @(negedge rst);
        cfg.enable = 1'b1;
        watch_pulses(5 * loop_cycles() + 32, ADJ_SLOWDOWN);
        if (pulse_cycles.size() == 0) begin
            $display("no slowdown pulse seen within five loops");
            errors++;
        end
        @(negedge rst);
        cfg.enable = 1'b0;
        finish_test("slow_master", errors_before);
    endtask

    initial begin
        void'($urandom(83));
        rst            = 1'b0;
        bitclk_master  = 1'b0;
        bitclk_local   = 1'b1;
        cfg            = '0;
        cycle_no       = 0;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        gap            = 32 + int'($urandom % 96);
        cfg.sample_len = SAMPLE_W'(SAMPLE_LEN);
        cfg.sample_gap = SAMPLE_W'(gap);

        repeat (RESET_CYCLES) @(negedge rst);
        bitclk_local = 1'b0;

        idle_after_reset();
        fast_master_speedup();
        pulse_spacing();
        disable_mid_run();
        slow_master_slowdown();

        $display("tests run %0d, failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, DUT.u_props.fail_count);
        if (errors == 0 && DUT.u_props.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
rtl/fll_pkg.sv
rtl/fll_sequencer.sv
rtl/domain_word_tracker.sv
rtl/master_sample_counter.sv
rtl/fll_decision.sv
rtl/fll_top.sv
tests/fll_props.sv
tests/fll_tb.sv
